//--- Bender.yml
package:
  name: drum_patch

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/drum_pkg.sv
      - rtl/node_plane_ram.sv
      - rtl/plane_arbiter.sv
      - rtl/node_update.sv
      - rtl/sweep_engine.sv
      - rtl/host_port.sv
      - rtl/drum_patch.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - dv/drum_patch_tb.sv

//--- drum_patch.f
+incdir+rtl
rtl/drum_pkg.sv
rtl/node_plane_ram.sv
rtl/plane_arbiter.sv
rtl/node_update.sv
rtl/sweep_engine.sv
rtl/host_port.sv
rtl/drum_patch.sv
dv/drum_patch_tb.sv

//--- dv/drum_patch_tb.sv
`timescale 1ns/100ps

`include "drum_settings.svh"

module drum_patch_tb
	import drum_pkg::*;
();

	localparam int CYCLE_LIMIT = 20 * 200;	// 20 sweeps of 200 cycles
	localparam int NODE_HI = (2 ** (`DRUM_NODE_W - 1)) - 1;
	localparam int NODE_LO = -(2 ** (`DRUM_NODE_W - 1));

	logic        clock;
	logic        reset;
	logic        run;
	node_t       rho;
	logic        host_we;
	logic        host_re;
	plane_role_e host_role;
	node_addr_t  host_addr;
	node_t       host_wdata;
	logic        host_rvalid;
	node_t       host_rdata;
	logic        sweep_done;
	logic        busy;

	string test_name;
	int    cycles;
	int    lat;
	node_t shadow [3][`DRUM_NODES];	// reference planes, indexed by role
	node_t exp_q [$];		// expected read data, oldest first

	drum_patch UUT (
		.clock       (clock),
		.reset       (reset),
		.run         (run),
		.rho         (rho),
		.host_we     (host_we),
		.host_re     (host_re),
		.host_role   (host_role),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.sweep_done  (sweep_done),
		.busy        (busy)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display(">>> FAIL");
			$fatal(1, "cycle limit reached");
		end
	end

	task automatic check_value(input string what, input logic signed [31:0] expected,
		input logic signed [31:0] actual);
		if (expected !== actual) begin
			$display("** Error [%s] %s: expected %0d, actual %0d",
				test_name, what, expected, actual);
			$display(">>> FAIL");
			$fatal(1, "value mismatch");
		end
	endtask

	// every returned read is matched against the oldest expectation
	always @(negedge clock) begin
		if (reset && host_rvalid) begin
			if (exp_q.size() == 0) begin
				$display("host_rvalid pulsed while no host read was outstanding");
				$display(">>> FAIL");
				$fatal(1, "unexpected read return");
			end else begin
				check_value("host_rdata", exp_q.pop_front(), host_rdata);
			end
		end
	end

	// wave update of one node, full-width product then clip
	function automatic node_t ref_node(node_t p, node_t c, node_t r, node_t l, node_t u,
		node_t d, node_t k);
		longint lap;
		longint prod;
		longint total;
		lap   = longint'(r) + longint'(l) + longint'(u) + longint'(d) - 4 * longint'(c);
		prod  = lap * longint'(k);
		total = (prod >>> `DRUM_FRAC_BITS) + 2 * longint'(c) - longint'(p);
		if (total > NODE_HI) begin
			total = NODE_HI;
		end else if (total < NODE_LO) begin
			total = NODE_LO;
		end
		return node_t'(total);
	endfunction

	// clamped rim, nothing outside the patch
	function automatic node_t cur_at(int r, int c);
		if (r < 0 || c < 0 || r >= `DRUM_GRID || c >= `DRUM_GRID) begin
			return '0;
		end
		return shadow[1][r * `DRUM_GRID + c];
	endfunction

	function automatic void model_sweep(node_t k);
		node_t nxt [`DRUM_NODES];
		int n;
		for (int r = 0; r < `DRUM_GRID; r++) begin
			for (int c = 0; c < `DRUM_GRID; c++) begin
				n = r * `DRUM_GRID + c;
				nxt[n] = ref_node(shadow[0][n], shadow[1][n], cur_at(r, c + 1),
					cur_at(r, c - 1), cur_at(r - 1, c), cur_at(r + 1, c), k);
			end
		end
		for (int i = 0; i < `DRUM_NODES; i++) begin
			shadow[2][i] = shadow[0][i];	// old prev is reused as next
			shadow[0][i] = shadow[1][i];
			shadow[1][i] = nxt[i];
		end
	endfunction

	function automatic node_t rand_amp(int span);
		int v;
		v = int'($urandom_range(0, 2 * span)) - span;
		return node_t'(v);
	endfunction

	task automatic write_node(input plane_role_e role, input node_addr_t addr, input node_t value);
		@(posedge clock);
		#1;
		host_we    = 1'b1;
		host_role  = role;
		host_addr  = addr;
		host_wdata = value;
		@(posedge clock);
		#1;
		host_we = 1'b0;
		shadow[int'(role)][addr] = value;
	endtask

	// latency counts clock edges from the strobe to host_rvalid
	task automatic read_node(input plane_role_e role, input node_addr_t addr, output int cnt);
		exp_q.push_back(shadow[int'(role)][addr]);
		@(posedge clock);
		#1;
		host_re   = 1'b1;
		host_role = role;
		host_addr = addr;
		@(posedge clock);
		#1;
		host_re = 1'b0;
		cnt = 1;
		@(negedge clock);
		while (!host_rvalid) begin
			@(negedge clock);
			cnt++;
		end
	endtask

	task automatic check_plane(input plane_role_e role);
		int unused_lat;
		for (int n = 0; n < `DRUM_NODES; n++) begin
			read_node(role, node_addr_t'(n), unused_lat);
		end
	endtask

	task automatic start_sweep(input node_t k);
		@(posedge clock);
		#1;
		run = 1'b1;
		rho = k;	// held until the next sweep
		@(posedge clock);
		#1;
		run = 1'b0;
	endtask

	// engine stays busy until the sweep completes
	task automatic wait_sweep();
		@(negedge clock);
		while (!sweep_done) begin
			check_value("busy", 1, busy);
			@(negedge clock);
		end
	endtask

	initial begin
		node_t       k;
		int          row;
		int          col;
		plane_role_e wr_role [8];
		node_addr_t  wr_addr [8];
		void'($urandom(71));
		reset      = 1'b0;
		run        = 1'b0;
		rho        = '0;
		host_we    = 1'b0;
		host_re    = 1'b0;
		host_role  = role_prev;
		host_addr  = '0;
		host_wdata = '0;
		test_name  = "reset";
		for (int p = 0; p < 3; p++) begin
			for (int n = 0; n < `DRUM_NODES; n++) begin
				shadow[p][n] = '0;
			end
		end
		repeat (3) @(posedge clock);
		#1 reset = 1'b1;

		repeat (20) begin
			@(negedge clock);
			check_value("sweep_done", 0, sweep_done);
			check_value("host_rvalid", 0, host_rvalid);
			check_value("busy", 0, busy);
		end

		test_name = "load_readback";
		for (int i = 0; i < 8; i++) begin
			wr_role[i] = plane_role_e'(i % 2);	// both planes get loaded
			wr_addr[i] = node_addr_t'($urandom_range(0, 15));
			write_node(wr_role[i], wr_addr[i], rand_amp(16384));
		end
		for (int i = 0; i < 8; i++) begin
			read_node(wr_role[i], wr_addr[i], lat);
			check_value("read latency", 2, lat);
		end

		test_name = "single_sweep";
		for (int n = 0; n < `DRUM_NODES; n++) begin
			row = n / `DRUM_GRID;
			col = n % `DRUM_GRID;
			write_node(role_prev, node_addr_t'(n), '0);
			if (row >= 1 && row <= 2 && col >= 1 && col <= 2) begin	// centre strike
				write_node(role_cur, node_addr_t'(n), rand_amp(16384));
			end else begin
				write_node(role_cur, node_addr_t'(n), '0);
			end
		end
		k = node_t'($urandom_range(0, 32767));
		start_sweep(k);
		wait_sweep();
		model_sweep(k);
		check_plane(role_cur);
		check_plane(role_prev);	// old current plane

		test_name = "multi_step";
		repeat (8) begin
			k = node_t'($urandom_range(0, 32767));
			start_sweep(k);
			wait_sweep();
			model_sweep(k);
			check_plane(role_cur);
		end

		test_name = "contention";
		k = node_t'($urandom_range(0, 32767));
		start_sweep(k);
		repeat (6) begin
			read_node(role_prev, node_addr_t'($urandom_range(0, 15)), lat);
		end
		wait_sweep();
		model_sweep(k);
		check_plane(role_cur);

		test_name = "saturation";
		for (int n = 0; n < `DRUM_NODES; n++) begin
			write_node(role_prev, node_addr_t'(n), rand_amp(NODE_HI - 2048));
			write_node(role_cur, node_addr_t'(n), rand_amp(NODE_HI - 2048));
		end
		k = node_t'(NODE_HI);	// rho just under one
		start_sweep(k);
		wait_sweep();
		model_sweep(k);
		check_plane(role_cur);

		repeat (4) @(negedge clock);
		if (exp_q.size() != 0) begin
			$display("%0d host reads never returned data", exp_q.size());
			$display(">>> FAIL");
			$fatal(1, "reads left outstanding");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

//--- rtl/drum_patch.sv
`timescale 1ns/100ps

module drum_patch
	import drum_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        run,
	input  node_t       rho,
	input  logic        host_we,
	input  logic        host_re,
	input  plane_role_e host_role,
	input  node_addr_t  host_addr,
	input  node_t       host_wdata,
	output logic        host_rvalid,
	output node_t       host_rdata,
	output logic        sweep_done,
	output logic        busy
);

	mem_req_t   host_req;
	mem_req_t   eng_req;
	logic       host_grant;
	logic       eng_grant;
	logic       rotate;
	logic       host_busy;
	logic       eng_busy;
	logic       mem_we;
	logic [1:0] mem_plane;
	node_addr_t mem_addr;
	node_t      mem_wdata;
	node_t      node_rdata;	// shared by both peers

	host_port u_host_port (
		.clock       (clock),
		.reset       (reset),
		.host_we     (host_we),
		.host_re     (host_re),
		.host_role   (host_role),
		.host_addr   (host_addr),
		.host_wdata  (host_wdata),
		.grant       (host_grant),
		.node_rdata  (node_rdata),
		.req         (host_req),
		.host_rvalid (host_rvalid),
		.host_rdata  (host_rdata),
		.busy        (host_busy)
	);

	sweep_engine u_sweep_engine (
		.clock      (clock),
		.reset      (reset),
		.run        (run),
		.rho        (rho),
		.grant      (eng_grant),
		.node_rdata (node_rdata),
		.req        (eng_req),
		.rotate     (rotate),
		.sweep_done (sweep_done),
		.busy       (eng_busy)
	);

	plane_arbiter u_plane_arbiter (
		.clock      (clock),
		.reset      (reset),
		.host_req   (host_req),
		.eng_req    (eng_req),
		.rotate     (rotate),
		.host_grant (host_grant),
		.eng_grant  (eng_grant),
		.mem_we     (mem_we),
		.mem_plane  (mem_plane),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata)
	);

	node_plane_ram u_node_plane_ram (
		.clock (clock),
		.we    (mem_we),
		.plane (mem_plane),
		.addr  (mem_addr),
		.wdata (mem_wdata),
		.rdata (node_rdata)
	);

	assign busy = host_busy | eng_busy;

endmodule

//--- rtl/drum_pkg.sv
`include "drum_settings.svh"

package drum_pkg;

	typedef logic signed [`DRUM_NODE_W-1:0] node_t;	// displacement value

	typedef logic [`DRUM_ADDR_W-1:0] node_addr_t;	// row * grid + col

	// logical role of a plane, mapped to a physical plane by the arbiter
	typedef enum logic [1:0] {
		role_prev = 2'd0,
		role_cur  = 2'd1,
		role_next = 2'd2
	} plane_role_e;

	// one memory request from a peer
	typedef struct packed {
		logic        req;	// held until granted
		logic        we;
		plane_role_e role;
		node_addr_t  addr;
		node_t       wdata;
	} mem_req_t;

	typedef enum logic [2:0] {
		idle,
		read_prev,
		read_cur,
		read_nbr,	// right, left, up, down in turn
		compute,	// last operand lands here
		write_next,
		rotate		// roles advance
	} engine_state_e;

endpackage

//--- rtl/drum_settings.svh
`ifndef DRUM_SETTINGS_SVH
`define DRUM_SETTINGS_SVH

// displacement word, signed fixed point
`define DRUM_NODE_W 18

// rho is scaled by 2^DRUM_FRAC_BITS
`define DRUM_FRAC_BITS 17

// patch geometry
`define DRUM_GRID 4
`define DRUM_NODES 16

// node address is row * DRUM_GRID + col
`define DRUM_ADDR_W 4

// prev, cur and next time steps
`define DRUM_PLANES 3

`endif

//--- rtl/host_port.sv
`timescale 1ns/100ps

module host_port
	import drum_pkg::*;
(
	input  logic        clock,
	input  logic        reset,
	input  logic        host_we,
	input  logic        host_re,
	input  plane_role_e host_role,
	input  node_addr_t  host_addr,
	input  node_t       host_wdata,
	input  logic        grant,
	input  node_t       node_rdata,
	output mem_req_t    req,
	output logic        host_rvalid,
	output node_t       host_rdata,
	output logic        busy
);

	logic     strobe;
	logic     pend_q;	// request waiting for grant
	mem_req_t hold_q;	// fields of the waiting request
	logic     ret_q;	// granted read, data due now

	assign strobe = host_we | host_re;

	// a strobe is presented in its own cycle, then held
	always_comb begin
		if (strobe) begin
			req.req   = 1'b1;
			req.we    = host_we;
			req.role  = host_role;
			req.addr  = host_addr;
			req.wdata = host_wdata;
		end else begin
			req     = hold_q;
			req.req = pend_q;
		end
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			pend_q      <= 1'b0;
			ret_q       <= 1'b0;
			host_rvalid <= 1'b0;
		end else begin
			pend_q      <= req.req & ~grant;
			ret_q       <= req.req & grant & ~req.we;
			host_rvalid <= ret_q;
		end
	end

	always_ff @(posedge clock) begin
		if (strobe) begin
			hold_q <= req;
		end
		if (ret_q) begin
			host_rdata <= node_rdata;	// ram output one cycle after grant
		end
	end

	assign busy = req.req | ret_q;

endmodule

//--- rtl/node_plane_ram.sv
`timescale 1ns/100ps

`include "drum_settings.svh"

module node_plane_ram
	import drum_pkg::*;
(
	input  logic       clock,
	input  logic       we,
	input  logic [1:0] plane,
	input  node_addr_t addr,
	input  node_t      wdata,
	output node_t      rdata
);

	localparam int DEPTH = `DRUM_PLANES * `DRUM_NODES;

	node_t mem [DEPTH];	// three planes back to back
	logic [$clog2(DEPTH)-1:0] idx;

	// each plane occupies one block of DRUM_NODES words
	assign idx = {plane, addr};

	always_ff @(posedge clock) begin
		if (we) begin
			mem[idx] <= wdata;
		end
	end

	// registered read, left alone during a write
	always_ff @(posedge clock) begin
		if (!we) begin
			rdata <= mem[idx];
		end
	end

endmodule

//--- rtl/node_update.sv
`timescale 1ns/100ps

`include "drum_settings.svh"

module node_update (
	input  drum_pkg::node_t u_prev,
	input  drum_pkg::node_t u_cur,
	input  drum_pkg::node_t u_right,
	input  drum_pkg::node_t u_left,
	input  drum_pkg::node_t u_up,
	input  drum_pkg::node_t u_down,
	input  drum_pkg::node_t rho,
	output drum_pkg::node_t u_next
);

	localparam int LAP_W  = `DRUM_NODE_W + 3;	// four neighbours plus 4 * u_cur
	localparam int PROD_W = LAP_W + `DRUM_NODE_W;
	localparam int SUM_W  = PROD_W + 2;

	localparam logic signed [SUM_W-1:0] NODE_MAX = SUM_W'((2 ** (`DRUM_NODE_W - 1)) - 1);
	localparam logic signed [SUM_W-1:0] NODE_MIN = -SUM_W'(2 ** (`DRUM_NODE_W - 1));

	logic signed [LAP_W-1:0]  lap;
	logic signed [PROD_W-1:0] prod;
	logic signed [SUM_W-1:0]  total;

	always_comb begin
		lap   = u_right + u_left + u_up + u_down - (u_cur <<< 2);
		prod  = lap * rho;	// full width, no rounding
		total = (prod >>> `DRUM_FRAC_BITS) + (u_cur <<< 1) - u_prev;

		// clip to the node range
		if (total > NODE_MAX) begin
			u_next = NODE_MAX[`DRUM_NODE_W-1:0];
		end else if (total < NODE_MIN) begin
			u_next = NODE_MIN[`DRUM_NODE_W-1:0];
		end else begin
			u_next = total[`DRUM_NODE_W-1:0];
		end
	end

endmodule

//--- rtl/plane_arbiter.sv
`timescale 1ns/100ps

`include "drum_settings.svh"

module plane_arbiter
	import drum_pkg::*;
(
	input  logic       clock,
	input  logic       reset,
	input  mem_req_t   host_req,
	input  mem_req_t   eng_req,
	input  logic       rotate,
	output logic       host_grant,
	output logic       eng_grant,
	output logic       mem_we,
	output logic [1:0] mem_plane,
	output node_addr_t mem_addr,
	output node_t      mem_wdata
);

	logic [1:0] rot_q;	// 0 .. planes-1
	mem_req_t   win;
	logic [2:0] plane_sum;

	// host has fixed priority, engine waits
	assign host_grant = host_req.req;
	assign eng_grant  = eng_req.req & ~host_req.req;

	assign win = host_req.req ? host_req : eng_req;

	always_ff @(posedge clock) begin
		if (!reset) begin
			rot_q <= '0;
		end else if (rotate) begin
			rot_q <= (rot_q == 2'(`DRUM_PLANES - 1)) ? 2'd0 : rot_q + 2'd1;
		end
	end

	// physical plane = (role + rotation) mod planes
	always_comb begin
		plane_sum = {1'b0, win.role} + {1'b0, rot_q};
		if (plane_sum >= 3'(`DRUM_PLANES)) begin
			plane_sum = plane_sum - 3'(`DRUM_PLANES);
		end
		mem_plane = plane_sum[1:0];
	end

	assign mem_we    = win.req & win.we;
	assign mem_addr  = win.addr;
	assign mem_wdata = win.wdata;

endmodule

//--- rtl/sweep_engine.sv
`timescale 1ns/100ps

`include "drum_settings.svh"

module sweep_engine
	import drum_pkg::*;
(
	input  logic     clock,
	input  logic     reset,
	input  logic     run,
	input  node_t    rho,
	input  logic     grant,
	input  node_t    node_rdata,
	output mem_req_t req,
	output logic     rotate,
	output logic     sweep_done,
	output logic     busy
);

	engine_state_e state_q;
	node_addr_t    node_q;		// node being updated
	logic [3:0]    nbr_todo_q;	// neighbours still to read
	logic          cap_pend_q;	// read data arrives this cycle
	logic [2:0]    cap_sel_q;	// 0 prev, 1 cur, 2.. neighbours
	node_t         prev_q;
	node_t         cur_q;
	node_t         nbr_q [4];	// right, left, up, down
	node_t         u_next;

	node_addr_t row;
	node_addr_t col;
	logic [3:0] nbr_ok;
	logic [1:0] nbr_idx;
	logic       last_nbr;
	node_addr_t nbr_addr;

	// neighbours outside the patch are skipped and stay zero
	always_comb begin
		row       = node_addr_t'(node_q / `DRUM_GRID);
		col       = node_addr_t'(node_q % `DRUM_GRID);
		nbr_ok[0] = (col != node_addr_t'(`DRUM_GRID - 1));
		nbr_ok[1] = (col != '0);
		nbr_ok[2] = (row != '0);
		nbr_ok[3] = (row != node_addr_t'(`DRUM_GRID - 1));
	end

	// lowest pending neighbour goes first
	always_comb begin
		nbr_idx = '0;
		for (int i = 3; i >= 0; i--) begin
			if (nbr_todo_q[i]) begin
				nbr_idx = 2'(i);
			end
		end
		last_nbr = (nbr_todo_q & ~(4'b0001 << nbr_idx)) == '0;
	end

	always_comb begin
		case (nbr_idx)
			2'd0:    nbr_addr = node_q + 1'b1;
			2'd1:    nbr_addr = node_q - 1'b1;
			2'd2:    nbr_addr = node_q - node_addr_t'(`DRUM_GRID);
			default: nbr_addr = node_q + node_addr_t'(`DRUM_GRID);
		endcase
	end

	always_comb begin
		req       = '0;
		req.role  = role_prev;
		req.addr  = node_q;
		req.wdata = u_next;
		case (state_q)
			read_prev: req.req = 1'b1;
			read_cur: begin
				req.req  = 1'b1;
				req.role = role_cur;
			end
			read_nbr: begin
				req.req  = 1'b1;
				req.role = role_cur;	// neighbours from the current plane
				req.addr = nbr_addr;
			end
			write_next: begin
				req.req  = 1'b1;
				req.we   = 1'b1;
				req.role = role_next;
			end
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!reset) begin
			state_q    <= idle;
			node_q     <= '0;
			nbr_todo_q <= '0;
			cap_pend_q <= 1'b0;
			sweep_done <= 1'b0;
		end else begin
			cap_pend_q <= grant && (state_q == read_prev || state_q == read_cur ||
				state_q == read_nbr);
			sweep_done <= (state_q == drum_pkg::rotate);	// one cycle after rotate
			case (state_q)
				idle: begin
					if (run) begin
						node_q  <= '0;
						state_q <= read_prev;
					end
				end
				read_prev: begin
					if (grant) begin
						state_q <= read_cur;
					end
				end
				read_cur: begin
					if (grant) begin
						nbr_todo_q <= nbr_ok;
						state_q    <= (nbr_ok == '0) ? compute : read_nbr;
					end
				end
				read_nbr: begin
					if (grant) begin
						nbr_todo_q[nbr_idx] <= 1'b0;
						if (last_nbr) begin
							state_q <= compute;
						end
					end
				end
				compute: state_q <= write_next;
				write_next: begin
					if (grant) begin
						if (node_q == node_addr_t'(`DRUM_NODES - 1)) begin
							state_q <= drum_pkg::rotate;
						end else begin
							node_q  <= node_q + 1'b1;
							state_q <= read_prev;
						end
					end
				end
				drum_pkg::rotate: state_q <= idle;
				default: state_q <= idle;
			endcase
		end
	end

	// operand capture, next read goes out in the same cycle
	always_ff @(posedge clock) begin
		if (grant) begin
			case (state_q)
				read_prev: cap_sel_q <= 3'd0;
				read_cur:  cap_sel_q <= 3'd1;
				read_nbr:  cap_sel_q <= 3'd2 + nbr_idx;
				default: ;
			endcase
		end
		if (state_q == read_prev && grant) begin
			for (int i = 0; i < 4; i++) begin
				nbr_q[i] <= '0;	// clamped rim
			end
		end
		if (cap_pend_q) begin
			case (cap_sel_q)
				3'd0:    prev_q <= node_rdata;
				3'd1:    cur_q  <= node_rdata;
				default: nbr_q[2'(cap_sel_q - 3'd2)] <= node_rdata;
			endcase
		end
	end

	node_update u_node_update (
		.u_prev  (prev_q),
		.u_cur   (cur_q),
		.u_right (nbr_q[0]),
		.u_left  (nbr_q[1]),
		.u_up    (nbr_q[2]),
		.u_down  (nbr_q[3]),
		.rho     (rho),
		.u_next  (u_next)
	);

	assign rotate = (state_q == drum_pkg::rotate);
	assign busy   = (state_q != idle);

endmodule
